// File: bpu_subsys.f
+incdir+include
source/bpu_pkg.sv
source/bpu.sv
source/fetch_queue.sv
source/branch_resolver.sv
source/bpu_subsys_top.sv
sim/bpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module bpu_tb -f bpu_subsys.f -o bpu_sim \
    && ./obj_dir/bpu_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation run ok" \
    || { echo "simulation run failed"; exit 1; }

exit 0

// File: sim/bpu_tb.sv
// branch prediction front end testbench
`timescale 1ns/1ps
`default_nettype none
`include "bpu_params.svh"

module bpu_tb;

    typedef bpu_pkg::resolve_info_t [1:0] resolve_pair_t;

    localparam logic [31:0] BASE = `BPU_INIT_PC;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_ready;
    resolve_pair_t          resolve;
    logic                   fetch_valid;
    bpu_pkg::fetch_pkt_t    fetch_pkt;

    // scoreboard state
    logic [31:0]            exp_pc;         // next packet the program must show
    logic [31:0]            lfsr_state;
    logic [4:0]             cond_hist;      // local history of the cond site
    logic [1:0]             cond_pht [32];  // its counters indexed by history
    bit                     trained [logic [31:0]];
    logic                   held;
    logic [31:0]            held_pc;
    logic                   rand_ready;
    int                     errors;
    int                     timeouts;
    int                     accepted;
    int                     cond_hits;      // cond predicted taken and right

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    bpu_subsys_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid_o (fetch_valid),
        .fetch_pkt_o   (fetch_pkt),
        .fetch_ready_i (fetch_ready),
        .resolve_i     (resolve)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // program table where every other address is a plain instruction
    function automatic bpu_pkg::resolve_info_t program_site(input logic [31:0] addr);
        bpu_pkg::resolve_info_t r;
        r = '0;
        case (addr - BASE)
            32'h0c: begin                   // bne taken every time
                r.br_type    = bpu_pkg::BR_NORMAL;
                r.is_cond_br = 1'b1;
                r.taken      = 1'b1;
                r.target_pc  = BASE + 32'h20;
            end
            32'h20: begin                   // bl into the long body
                r.br_type   = bpu_pkg::BR_CALL;
                r.taken     = 1'b1;
                r.target_pc = BASE + 32'h40;
            end
            32'h70: begin                   // jirl back past the bl
                r.br_type   = bpu_pkg::BR_RET;
                r.taken     = 1'b1;
                r.target_pc = BASE + 32'h24;
            end
            32'h28: begin                   // b closes the loop
                r.br_type   = bpu_pkg::BR_NORMAL;
                r.taken     = 1'b1;
                r.target_pc = BASE;
            end
            default: ;
        endcase
        program_site = r;
    endfunction

    // backend outcome for the block at pc
    function automatic resolve_pair_t build_resolve(input logic [31:0] pc);
        resolve_pair_t r;
        logic          done;
        r    = '0;
        done = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if ((i == 1 || !pc[2]) && !done) begin
                r[i] = program_site({pc[31:3], i[0], 2'b00});
                done = r[i].taken;  // younger slot never executes
            end
        end
        build_resolve = r;
    endfunction

    // accepted packet against the program and the predictor model
    task automatic check_packet;
        bpu_pkg::resolve_info_t act;
        bpu_pkg::br_type_e      exp_type;
        logic [31:0]            addr;
        logic [31:0]            next_pc;
        logic [4:0]             hist;
        logic [1:0]             scnt;
        logic                   exp_taken;
        logic                   known;
        logic                   done;

        assert (fetch_pkt.pc == exp_pc) else begin
            $display("ERROR %0t: packet pc %h, expected %h", $time, fetch_pkt.pc, exp_pc);
            errors++;
        end
        assert (fetch_pkt.mask == (exp_pc[2] ? 2'b10 : 2'b11)) else begin
            $display("ERROR %0t: mask %b for pc %h", $time, fetch_pkt.mask, exp_pc);
            errors++;
        end
        next_pc = {exp_pc[31:3], 3'b000} + 32'd8;   // fall into next block
        done    = 1'b0;
        for (int i = 0; i < 2; i++) begin
            addr = {exp_pc[31:3], i[0], 2'b00};
            act  = program_site(addr);
            if ((i == 1 || !exp_pc[2]) && !done && act.br_type != bpu_pkg::BR_NONE) begin
                known     = trained.exists(addr);
                hist      = known ? cond_hist : 5'd0;       // btb miss reads cold
                scnt      = known ? cond_pht[hist] : 2'd0;
                exp_taken = known && (act.is_cond_br ? scnt[1] : 1'b1);
                if (known) begin
                    exp_type = act.br_type;
                end else begin
                    exp_type = bpu_pkg::BR_NONE;
                end
                assert (fetch_pkt.pred[i].br_type == exp_type &&
                        fetch_pkt.pred[i].taken == exp_taken) else begin
                    $display("ERROR %0t: site %h predicted type %0d taken %b, expected %0d %b",
                             $time, addr, fetch_pkt.pred[i].br_type,
                             fetch_pkt.pred[i].taken, exp_type, exp_taken);
                    errors++;
                end
                if (exp_taken) begin
                    assert (fetch_pkt.pred[i].target_pc == act.target_pc) else begin
                        $display("ERROR %0t: site %h target %h, expected %h", $time,
                                 addr, fetch_pkt.pred[i].target_pc, act.target_pc);
                        errors++;
                    end
                    if (act.is_cond_br) begin
                        cond_hits++;
                    end
                end
                if (act.is_cond_br) begin
                    assert (fetch_pkt.pred[i].scnt == scnt &&
                            fetch_pkt.pred[i].history == hist) else begin
                        $display("ERROR %0t: site %h counter %0d history %b, expected %0d %b",
                                 $time, addr, fetch_pkt.pred[i].scnt,
                                 fetch_pkt.pred[i].history, scnt, hist);
                        errors++;
                    end
                    // saturating counter at the predicted index
                    if (act.taken) begin
                        cond_pht[hist] = (scnt == 2'd3) ? scnt : scnt + 2'd1;
                    end else begin
                        cond_pht[hist] = (scnt == 2'd0) ? scnt : scnt - 2'd1;
                    end
                    cond_hist = known ? {cond_hist[3:0], act.taken} : {4'd0, act.taken};
                end
                trained[addr] = 1'b1;
                if (act.taken) begin
                    next_pc = act.target_pc;
                    done    = 1'b1;
                end
            end
        end
        exp_pc = next_pc;
        accepted++;
    endtask

    task automatic sample_cycle;
        // a stalled head must still be there unchanged
        if (held) begin
            assert (fetch_valid && fetch_pkt.pc == held_pc) else begin
                $display("ERROR %0t: held packet %h left the head without a handshake",
                         $time, held_pc);
                errors++;
            end
        end
        held    = fetch_valid && !fetch_ready;
        held_pc = fetch_pkt.pc;
        if (fetch_valid && fetch_ready) begin
            check_packet();
        end
    endtask

    // drive until n more packets are taken or the cycle budget runs out
    task automatic run_traffic(input int n, input int max_cycles);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < max_cycles) begin
            @(posedge clk);
            if (rand_ready) begin
                lfsr_state = lfsr_next(lfsr_state);
                fetch_ready <= lfsr_state[0];
            end else begin
                fetch_ready <= 1'b1;
            end
            resolve <= build_resolve(exp_pc);   // outcome of the packet due next
            @(negedge clk);
            sample_cycle();
            cycles++;
        end
        if (accepted < target) begin
            $display("timeout: only %0d of %0d packets accepted within %0d cycles",
                     accepted, target, max_cycles);
            timeouts++;
        end
    endtask

    initial begin
        rst_n       <= 1'b0;
        fetch_ready <= 1'b0;
        resolve     <= '0;
        exp_pc     = BASE;
        lfsr_state = 32'haf8b;
        cond_hist  = 5'd0;
        for (int i = 0; i < 32; i++) begin
            cond_pht[i] = 2'd0;
        end
        held       = 1'b0;
        held_pc    = '0;
        rand_ready = 1'b0;
        errors     = 0;
        timeouts   = 0;
        accepted   = 0;
        cond_hits  = 0;

        // five reset edges and then one quiet cycle
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            assert (!fetch_valid) else begin
                $display("ERROR %0t: fetch_valid_o high right after reset", $time);
                errors++;
            end
        end

        run_traffic(40, 2000);      // backend always ready
        rand_ready = 1'b1;
        run_traffic(160, 6000);     // random back-pressure

        assert (cond_hits > 0) else begin
            $display("ERROR %0t: conditional branch never predicted taken", $time);
            errors++;
        end

        $display("bpu_tb: %0d packets, %0d errors, %0d timeouts", accepted, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/bpu_subsys_top.sv
// branch prediction front end top
`timescale 1ns/1ps
`default_nettype none

module bpu_subsys_top (
    input  wire                              clk,
    input  wire                              rst_n,
    output logic                             fetch_valid_o,
    output bpu_pkg::fetch_pkt_t              fetch_pkt_o,
    input  wire                              fetch_ready_i,
    input  wire  bpu_pkg::resolve_info_t [1:0] resolve_i
);

    logic                    pkt_valid;
    bpu_pkg::fetch_pkt_t     pkt;
    logic                    credit_return;
    logic                    head_valid;
    bpu_pkg::fetch_pkt_t     head_pkt;
    logic                    pop;
    bpu_pkg::correct_info_t  correct_info;
    logic                    g_flush;
    logic [31:0]             redirect_pc;

    bpu u_bpu (
        .clk             (clk),
        .rst_n           (rst_n),
        .g_flush_i       (g_flush),
        .redirect_pc_i   (redirect_pc),
        .correct_info_i  (correct_info),
        .credit_return_i (credit_return),
        .pkt_valid_o     (pkt_valid),
        .pkt_o           (pkt)
    );

    fetch_queue u_fetch_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .g_flush_i       (g_flush),
        .wr_valid_i      (pkt_valid),
        .wr_pkt_i        (pkt),
        .credit_return_o (credit_return),
        .head_valid_o    (head_valid),
        .head_pkt_o      (head_pkt),
        .pop_i           (pop)
    );

    branch_resolver u_branch_resolver (
        .clk             (clk),
        .rst_n           (rst_n),
        .head_valid_i    (head_valid),
        .head_pkt_i      (head_pkt),
        .pop_o           (pop),
        .fetch_valid_o   (fetch_valid_o),
        .fetch_pkt_o     (fetch_pkt_o),
        .fetch_ready_i   (fetch_ready_i),
        .resolve_i       (resolve_i),
        .correct_info_o  (correct_info),
        .g_flush_o       (g_flush),
        .redirect_pc_o   (redirect_pc)
    );

endmodule

`default_nettype wire

// File: source/branch_resolver.sv
// branch resolver, checks predictions and trains
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              head_valid_i,
    input  wire  bpu_pkg::fetch_pkt_t        head_pkt_i,
    output logic                             pop_o,
    output logic                             fetch_valid_o,
    output bpu_pkg::fetch_pkt_t              fetch_pkt_o,
    input  wire                              fetch_ready_i,
    input  wire  bpu_pkg::resolve_info_t [1:0] resolve_i,
    output bpu_pkg::correct_info_t           correct_info_o,
    output logic                             g_flush_o,
    output logic [31:0]                      redirect_pc_o
);

    logic                    accept;
    logic                    mispredict;
    logic [31:0]             redirect_d;
    bpu_pkg::correct_info_t  ci_d;

    // stale head is hidden while the queue flushes
    assign fetch_valid_o = head_valid_i && !g_flush_o;
    assign fetch_pkt_o   = head_pkt_i;
    assign accept        = fetch_valid_o && fetch_ready_i;
    assign pop_o         = accept;

    always_comb begin
        bpu_pkg::pred_info_t    p;
        bpu_pkg::resolve_info_t a;
        logic [31:0]            slot_pc;
        logic                   type_miss;
        logic                   tgt_miss;
        logic                   done;

        mispredict = 1'b0;
        redirect_d = '0;
        ci_d       = '0;
        done       = 1'b0;
        for (int i = 0; i < 2; i++) begin
            p         = head_pkt_i.pred[i];
            a         = resolve_i[i];
            slot_pc   = {head_pkt_i.pc[31:3], i[0], 2'b00};
            type_miss = p.br_type != a.br_type;
            tgt_miss  = a.taken && (p.target_pc != a.target_pc);
            if (head_pkt_i.mask[i] && !done) begin
                // first disagreeing slot decides the redirect
                if (!mispredict && (type_miss || tgt_miss || p.taken != a.taken)) begin
                    mispredict = 1'b1;
                    redirect_d = a.taken ? a.target_pc : slot_pc + 32'd4;
                end
                // train the first slot that is a branch on either side
                if (!ci_d.update &&
                    (p.br_type != bpu_pkg::BR_NONE || a.br_type != bpu_pkg::BR_NONE)) begin
                    ci_d.update      = 1'b1;
                    ci_d.pc          = slot_pc;
                    ci_d.br_type     = a.br_type;
                    ci_d.is_cond_br  = a.is_cond_br;
                    ci_d.taken       = a.taken;
                    ci_d.target_pc   = a.target_pc;
                    ci_d.scnt        = p.scnt;
                    ci_d.history     = p.history;
                    ci_d.type_miss   = type_miss;
                    ci_d.target_miss = tgt_miss;
                end
                done = a.taken;  // later slots never execute
            end
        end
        ci_d.update = ci_d.update && accept;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            g_flush_o             <= 1'b0;
            correct_info_o.update <= 1'b0;
        end else begin
            g_flush_o      <= accept && mispredict;  // single cycle pulse
            correct_info_o <= ci_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            redirect_pc_o <= redirect_d;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_queue.sv
// fetch packet queue with credit return
`timescale 1ns/1ps
`default_nettype none
`include "bpu_params.svh"

module fetch_queue (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      g_flush_i,
    input  wire                      wr_valid_i,
    input  wire  bpu_pkg::fetch_pkt_t wr_pkt_i,
    output logic                     credit_return_o,
    output logic                     head_valid_o,
    output bpu_pkg::fetch_pkt_t      head_pkt_o,
    input  wire                      pop_i
);

    bpu_pkg::fetch_pkt_t      mem [`FQ_DEPTH];
    logic [`FQ_PTR_LEN-1:0]   wptr;
    logic [`FQ_PTR_LEN-1:0]   rptr;
    logic [`FQ_PTR_LEN:0]     count;
    logic                     do_push;
    logic                     do_pop;

    // credits upstream guarantee a free slot on every push
    assign do_push = wr_valid_i && !g_flush_i;
    assign do_pop  = pop_i && head_valid_o && !g_flush_i;

    assign head_valid_o    = count != '0;
    assign head_pkt_o      = mem[rptr];
    assign credit_return_o = do_pop;  // one credit per pop

    always_ff @(posedge clk) begin
        if (!rst_n || g_flush_i) begin
            // dropped packets give back no credit
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + {{`FQ_PTR_LEN{1'b0}}, do_push}
                           - {{`FQ_PTR_LEN{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr] <= wr_pkt_i;  // visible at head next cycle
        end
    end

endmodule

`default_nettype wire

// File: source/bpu.sv
// two-slot branch predictor
`timescale 1ns/1ps
`default_nettype none
`include "bpu_params.svh"

module bpu (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         g_flush_i,
    input  wire  [31:0]                 redirect_pc_i,
    input  wire  bpu_pkg::correct_info_t correct_info_i,
    input  wire                         credit_return_i,
    output logic                        pkt_valid_o,
    output bpu_pkg::fetch_pkt_t         pkt_o
);

    // folds pc[17:3] down to the btb index
    function automatic logic [`BPU_BTB_LEN-1:0] btb_hash(input logic [31:0] addr);
        btb_hash = addr[17:9] ^ addr[11:3];
    endfunction

    function automatic logic [`BPU_TAG_LEN-1:0] btb_tag(input logic [31:0] addr);
        btb_tag = addr[`BPU_TAG_LEN+11:12];
    endfunction

    logic [31:0]              pc;
    logic [31:0]              npc;
    logic [`FQ_PTR_LEN:0]     credits;      // free queue slots
    logic                     fetch_en;     // low in the first cycle out of reset

    // tables with one bank per slot
    bpu_pkg::btb_entry_t         btb_mem [2][`BPU_BTB_DEPTH];
    logic [1:0][`BPU_BTB_DEPTH-1:0] btb_vld;  // entry valid bits per bank
    logic [`BPU_HISTORY_LEN-1:0] bht_mem [2][`BPU_BTB_DEPTH];
    logic [1:0]                  pht_mem [2][2**`BPU_PHT_LEN];
    logic [31:0]                 ras_mem [`BPU_RAS_DEPTH];
    logic [`BPU_RAS_LEN-1:0]     ras_sp;       // points at top entry
    logic [`BPU_RAS_LEN-1:0]     ras_wptr;

    logic [`BPU_BTB_LEN-1:0]     rd_idx;
    logic [`BPU_BTB_LEN-1:0]     wr_idx;
    logic                        wr_bank;
    bpu_pkg::btb_entry_t [1:0]   btb_rd;
    logic [1:0]                  btb_hit;
    logic [1:0]                  taken;
    logic [1:0][`BPU_HISTORY_LEN-1:0] hist_rd;
    logic [1:0][1:0]             scnt_rd;
    logic [1:0][31:0]            fall_pc;

    bpu_pkg::btb_entry_t         btb_wdata;
    logic                        btb_we;
    logic [`BPU_HISTORY_LEN-1:0] new_hist;
    logic [1:0]                  new_scnt;
    logic                        ras_push;
    logic                        ras_pop;

    // lookup
    assign rd_idx     = btb_hash(pc);
    assign fall_pc[0] = {pc[31:3], 3'b100};
    assign fall_pc[1] = {pc[31:3] + 29'd1, 3'b000};

    always_comb begin
        pkt_o.pc   = pc;
        pkt_o.mask = {1'b1, !pc[2]};   // slot 0 dropped when entering at pc+4
        for (int i = 0; i < 2; i++) begin
            btb_rd[i]  = btb_mem[i][rd_idx];
            btb_hit[i] = btb_vld[i][rd_idx] && btb_rd[i].valid &&
                         (btb_rd[i].tag == btb_tag(pc));
            // miss reads as cold history and counter
            hist_rd[i] = btb_hit[i] ? bht_mem[i][rd_idx] : '0;
            scnt_rd[i] = btb_hit[i] ? pht_mem[i][{hist_rd[i], pc[`BPU_PHT_PC_LEN+2:3]}] : 2'b00;
            taken[i]   = btb_hit[i] && (!btb_rd[i].is_cond_br || scnt_rd[i][1]);

            pkt_o.pred[i].br_type = btb_hit[i] ? btb_rd[i].br_type : bpu_pkg::BR_NONE;
            pkt_o.pred[i].taken   = taken[i];
            pkt_o.pred[i].scnt    = scnt_rd[i];
            pkt_o.pred[i].history = hist_rd[i];
            if (!taken[i]) begin
                pkt_o.pred[i].target_pc = fall_pc[i];
            end else if (btb_rd[i].br_type == bpu_pkg::BR_RET) begin
                pkt_o.pred[i].target_pc = ras_mem[ras_sp];  // return from ras top
            end else begin
                pkt_o.pred[i].target_pc = btb_rd[i].target_pc;
            end
        end
        // slot 0 only counts when it is in the block
        npc = (taken[0] && !pc[2]) ? pkt_o.pred[0].target_pc : pkt_o.pred[1].target_pc;
    end

    // send only with a free queue slot and no flush
    assign pkt_valid_o = fetch_en && (credits != '0) && !g_flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `BPU_INIT_PC;
            credits <= (`FQ_PTR_LEN+1)'(`FQ_DEPTH);
        end else if (g_flush_i) begin
            pc      <= redirect_pc_i;
            credits <= (`FQ_PTR_LEN+1)'(`FQ_DEPTH);  // queue empties itself
        end else begin
            if (pkt_valid_o) begin
                pc <= npc;
            end
            credits <= credits - {{`FQ_PTR_LEN{1'b0}}, pkt_valid_o}
                               + {{`FQ_PTR_LEN{1'b0}}, credit_return_i};
        end
    end

    // training
    assign wr_idx  = btb_hash(correct_info_i.pc);
    assign wr_bank = correct_info_i.pc[2];
    assign btb_we  = correct_info_i.update &&
                     (correct_info_i.type_miss || correct_info_i.target_miss);

    always_comb begin
        btb_wdata.valid      = correct_info_i.br_type != bpu_pkg::BR_NONE;  // NONE evicts
        btb_wdata.tag        = btb_tag(correct_info_i.pc);
        btb_wdata.br_type    = correct_info_i.br_type;
        btb_wdata.is_cond_br = correct_info_i.is_cond_br;
        btb_wdata.target_pc  = correct_info_i.target_pc;

        // wrong type means stale history so start over
        new_hist = correct_info_i.type_miss ?
                   {{(`BPU_HISTORY_LEN-1){1'b0}}, correct_info_i.taken} :
                   {correct_info_i.history[`BPU_HISTORY_LEN-2:0], correct_info_i.taken};

        new_scnt = correct_info_i.scnt;
        if (correct_info_i.taken && correct_info_i.scnt != 2'b11) begin
            new_scnt = correct_info_i.scnt + 2'b01;
        end else if (!correct_info_i.taken && correct_info_i.scnt != 2'b00) begin
            new_scnt = correct_info_i.scnt - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btb_vld <= '0;
        end else if (btb_we) begin
            btb_vld[wr_bank][wr_idx] <= btb_wdata.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_we) begin
            btb_mem[wr_bank][wr_idx] <= btb_wdata;
        end
        if (correct_info_i.update) begin
            bht_mem[wr_bank][wr_idx] <= new_hist;
        end
        if (correct_info_i.update && correct_info_i.is_cond_br) begin
            // same index the prediction was read from
            pht_mem[wr_bank][{correct_info_i.history, correct_info_i.pc[`BPU_PHT_PC_LEN+2:3]}]
                <= new_scnt;
        end
    end

    // ras driven by resolved calls and returns only
    assign ras_push = correct_info_i.update && correct_info_i.br_type == bpu_pkg::BR_CALL;
    assign ras_pop  = correct_info_i.update && correct_info_i.br_type == bpu_pkg::BR_RET;
    assign ras_wptr = ras_sp + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ras_sp <= '1;  // first push lands in entry 0
        end else if (ras_push) begin
            ras_sp <= ras_wptr;
        end else if (ras_pop) begin
            ras_sp <= ras_sp - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ras_push) begin
            ras_mem[ras_wptr] <= correct_info_i.pc + 32'd4;  // link address
        end
    end

endmodule

`default_nettype wire

// File: source/bpu_pkg.sv
// branch prediction types
`default_nettype none
`include "bpu_params.svh"

package bpu_pkg;

    // NORMAL covers cond branches and B, CALL is BL, RET is JIRL
    typedef enum logic [1:0] {
        BR_NONE,
        BR_NORMAL,
        BR_CALL,
        BR_RET
    } br_type_e;

    typedef struct packed {
        logic                      valid;
        logic [`BPU_TAG_LEN-1:0]   tag;         // pc[19:12]
        br_type_e                  br_type;
        logic                      is_cond_br;
        logic [31:0]               target_pc;   // unused for RET, ras wins
    } btb_entry_t;

    // one slot of a fetch block
    typedef struct packed {
        br_type_e                    br_type;
        logic                        taken;
        logic [1:0]                  scnt;
        logic [`BPU_HISTORY_LEN-1:0] history;
        logic [31:0]                 target_pc;  // fall-through when not taken
    } pred_info_t;

    typedef struct packed {
        logic [31:0]       pc;
        logic [1:0]        mask;   // bit i set when slot i is in the block
        pred_info_t [1:0]  pred;
    } fetch_pkt_t;

    // what the backend actually saw for one slot
    typedef struct packed {
        br_type_e     br_type;
        logic         is_cond_br;
        logic         taken;
        logic [31:0]  target_pc;
    } resolve_info_t;

    typedef struct packed {
        logic                        update;
        logic [31:0]                 pc;        // slot address
        br_type_e                    br_type;
        logic                        is_cond_br;
        logic                        taken;
        logic [31:0]                 target_pc;
        logic [1:0]                  scnt;      // counter as predicted
        logic [`BPU_HISTORY_LEN-1:0] history;   // history as predicted
        logic                        type_miss;
        logic                        target_miss;
    } correct_info_t;

endpackage

`default_nettype wire

// File: include/bpu_params.svh
// predictor and queue sizes
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// fetch address out of reset
`define BPU_INIT_PC      32'h1c000000

// btb, indexed by hashed pc, tagged by pc[19:12]
`define BPU_BTB_LEN      9
`define BPU_BTB_DEPTH    512
`define BPU_TAG_LEN      8

// local history and pattern table
`define BPU_HISTORY_LEN  5
`define BPU_PHT_PC_LEN   8      // pc[10:3]
`define BPU_PHT_LEN      13     // history + pc bits

// return address stack
`define BPU_RAS_DEPTH    8
`define BPU_RAS_LEN      3

// fetch queue, also the credit count
`define FQ_DEPTH         4
`define FQ_PTR_LEN       2

`endif
